// File: bench/accel_input.txt
// columns: X sample, Y sample, both 16-bit hex, one X/Y read loop per line
// the sensor model returns each value low byte first, then high byte
0123 FEDC
8001 7FFE
00FF FF00
5A3C C3A5
0000 FFFF
1E0F F0E1
7FFF 8000
0042 FFBE
A55A 5AA5
0F0F F0F0

// File: bench/tb_adxl345_xy_reader.sv
`timescale 1ns/1ps

module tb_adxl345_xy_reader;
    import adxl_pkg::*;

    localparam int N_PAIRS       = 10;  // X/Y pairs in the data file
    localparam int LEAD_IN       = 11;  // closing count of the last frame and counts 0 to 9
    localparam int VALID_TIMEOUT = 400; // clocks, longer than reset to the first valid

    logic   i_clk   = 1'b0;
    logic   i_rst_n = 1'b0;
    logic   i_sdo   = 1'b0;
    logic   o_cs_n;
    logic   o_spc;
    logic   o_sdi;
    accel_t o_accel_x;
    accel_t o_accel_y;
    logic   o_accel_valid;

    accel_t samples [0:2*N_PAIRS-1]; // X at even entries, Y at odd ones

    // sensor model state, all of it moves on the falling clock edge
    logic       prev_spc       = 1'b1;
    logic       prev_cs_n      = 1'b1;
    logic [7:0] in_byte        = 8'h00;
    logic [7:0] addr_byte      = 8'h00;
    logic [7:0] reply_sr       = 8'h00;
    int         bit_cnt        = 0;
    int         frame_cnt      = 0;
    int         loop_done      = 0;
    int         cs_high_cycles = 0;

    always #2 i_clk = ~i_clk;

    adxl345_xy_reader UUT (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .o_cs_n        (o_cs_n),
        .o_spc         (o_spc),
        .o_sdi         (o_sdi),
        .i_sdo         (i_sdo),
        .o_accel_x     (o_accel_x),
        .o_accel_y     (o_accel_y),
        .o_accel_valid (o_accel_valid)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s is 0x%02h, expected 0x%02h", name, got, exp));
        end
    endtask

    task automatic compare_accel(input string name, input accel_t got, input accel_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s is 0x%04h, expected 0x%04h", name, got, exp));
        end
    endtask

    // two configuration writes, then the four data registers in a loop
    function automatic logic [7:0] expected_addr(input int frame_idx);
        logic [7:0] addr;
        if (frame_idx == 0) begin
            addr = 8'h2D;
        end else if (frame_idx == 1) begin
            addr = 8'h31;
        end else begin
            case ((frame_idx - 2) % 4)
                0:       addr = 8'hB2;
                1:       addr = 8'hB3;
                2:       addr = 8'hB4;
                default: addr = 8'hB5;
            endcase
        end
        return addr;
    endfunction

    function automatic logic [7:0] sensor_reply(input logic [7:0] cmd, input int loop_idx);
        logic [4:0] pair;
        logic [7:0] reply;
        pair = 5'((loop_idx % N_PAIRS) * 2);
        case (cmd[5:0])
            6'h32:   reply = samples[pair][7:0];
            6'h33:   reply = samples[pair][15:8];
            6'h34:   reply = samples[pair + 5'd1][7:0];
            6'h35:   reply = samples[pair + 5'd1][15:8];
            default: reply = 8'h00;
        endcase
        return reply;
    endfunction

    task automatic wait_for_valid();
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (!o_accel_valid) begin
            if (waited >= VALID_TIMEOUT) begin
                report_failure("timeout while waiting for an o_accel_valid pulse");
            end else begin
                @(negedge i_clk);
                waited++;
            end
        end
    endtask

    always @(negedge i_clk) begin : sensor_model
        logic [7:0] next_byte;
        next_byte      = {in_byte[6:0], o_sdi};
        prev_spc       <= o_spc;
        prev_cs_n      <= o_cs_n;
        cs_high_cycles <= o_cs_n ? cs_high_cycles + 1 : 0;
        if (!i_rst_n) begin
            bit_cnt <= 0;
            i_sdo   <= 1'b0;
        end else if (o_cs_n) begin
            if (!o_spc) begin
                report_failure("SPC went low while CS was high");
            end
            if (!prev_cs_n && !addr_byte[7] && bit_cnt != 16) begin
                report_failure("a write frame closed before all 16 bits were sent");
            end
            if (!prev_cs_n && addr_byte == 8'hB5) begin
                loop_done <= loop_done + 1; // Y high byte closes one X/Y loop
            end
            bit_cnt <= 0;
            i_sdo   <= 1'b0;
        end else begin
            if (prev_cs_n && cs_high_cycles < LEAD_IN) begin
                report_failure("CS went low before the idle lead-in was over");
            end
            if (prev_spc && !o_spc && bit_cnt >= 8 && addr_byte[7]) begin
                i_sdo    <= reply_sr[7]; // new bit on falling SPC, DUT takes it on the rise
                reply_sr <= {reply_sr[6:0], 1'b0};
            end
            if (!prev_spc && o_spc) begin
                bit_cnt <= bit_cnt + 1;
                in_byte <= next_byte;
                if (bit_cnt == 7) begin
                    compare_byte("o_sdi address byte", next_byte, expected_addr(frame_cnt));
                    addr_byte <= next_byte;
                    reply_sr  <= sensor_reply(next_byte, loop_done);
                    frame_cnt <= frame_cnt + 1;
                end
                if (bit_cnt == 15 && !addr_byte[7]) begin
                    compare_byte("o_sdi write data byte", next_byte, 8'h08); // both take 0x08
                end
            end
        end
    end

    initial begin : main_flow
        logic [4:0] pair;
        int         pulses;
        $readmemh("bench/accel_input.txt", samples);
        for (pulses = 0; pulses < 2 * N_PAIRS; pulses++) begin
            if ($isunknown(samples[5'(pulses)])) begin
                report_failure("bench/accel_input.txt is missing or holds too few values");
            end
        end
        repeat (2) @(negedge i_clk);
        compare_bit("o_cs_n", o_cs_n, 1'b1);
        compare_bit("o_spc", o_spc, 1'b1);
        compare_bit("o_sdi", o_sdi, 1'b0);
        compare_bit("o_accel_valid", o_accel_valid, 1'b0);
        compare_accel("o_accel_x", o_accel_x, 16'h0000);
        compare_accel("o_accel_y", o_accel_y, 16'h0000);
        i_rst_n <= 1'b1;
        for (pulses = 0; pulses < N_PAIRS; pulses++) begin
            wait_for_valid();
            if (loop_done != pulses + 1) begin
                report_failure("o_accel_valid did not line up with a finished X/Y read loop");
            end
            pair = 5'(2 * pulses);
            compare_accel("o_accel_x", o_accel_x, samples[pair]);
            compare_accel("o_accel_y", o_accel_y, samples[pair + 5'd1]);
            @(negedge i_clk);
            compare_bit("o_accel_valid", o_accel_valid, 1'b0); // strobe lasts one clock
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: design/adxl345_xy_reader.sv
`timescale 1ns/1ps

module adxl345_xy_reader (
    input  logic             i_clk,
    input  logic             i_rst_n,
    output logic             o_cs_n,
    output logic             o_spc,
    output logic             o_sdi,
    input  logic             i_sdo,
    output adxl_pkg::accel_t o_accel_x,
    output adxl_pkg::accel_t o_accel_y,
    output logic             o_accel_valid
);
    import adxl_pkg::*;

    spi_cmd_t   cmd;
    logic [7:0] rx_byte;
    logic       capture_lo;
    logic       commit_x;
    logic       commit_y;

    adxl_frame_if frame ();

    adxl_frame_timer u_timer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .frame   (frame.timer),
        .o_cs_n  (o_cs_n),
        .o_spc   (o_spc)
    );

    adxl_cmd_sequencer u_seq (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .frame        (frame.seq),
        .o_cmd        (cmd),
        .o_capture_lo (capture_lo),
        .o_commit_x   (commit_x),
        .o_commit_y   (commit_y)
    );

    adxl_spi_shifter u_shifter (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .frame     (frame.shifter),
        .i_cmd     (cmd),
        .i_sdo     (i_sdo),
        .o_sdi     (o_sdi),
        .o_rx_byte (rx_byte)
    );

    adxl_sample_store u_store (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_rx_byte     (rx_byte),
        .i_capture_lo  (capture_lo),
        .i_commit_x    (commit_x),
        .i_commit_y    (commit_y),
        .o_accel_x     (o_accel_x),
        .o_accel_y     (o_accel_y),
        .o_accel_valid (o_accel_valid)
    );

endmodule

// File: design/adxl_cmd_sequencer.sv
`timescale 1ns/1ps

module adxl_cmd_sequencer (
    input  logic              i_clk,
    input  logic              i_rst_n,
    adxl_frame_if.seq         frame,
    output adxl_pkg::spi_cmd_t o_cmd,
    output logic              o_capture_lo,
    output logic              o_commit_x,
    output logic              o_commit_y
);
    import adxl_pkg::*;

    seq_state_t state;
    seq_state_t next_state;

    always_comb begin
        case (state)
            CFG_POWER:  next_state = CFG_FORMAT;
            CFG_FORMAT: next_state = RD_XL; // configuration runs only once
            RD_XL:      next_state = RD_XH;
            RD_XH:      next_state = RD_YL;
            RD_YL:      next_state = RD_YH;
            RD_YH:      next_state = RD_XL;
            default:    next_state = CFG_POWER;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= CFG_POWER;
        end else if (frame.frame_done) begin
            state <= next_state;
        end
    end

    // reads send only the address, the zero data byte keeps SDI low afterwards
    always_comb begin
        case (state)
            CFG_POWER:  o_cmd = {REG_POWER_CTL, POWER_CTL_VAL};
            CFG_FORMAT: o_cmd = {REG_DATA_FORMAT, DATA_FORMAT_VAL};
            RD_XL:      o_cmd = {RD_X_LSB, 8'h00};
            RD_XH:      o_cmd = {RD_X_MSB, 8'h00};
            RD_YL:      o_cmd = {RD_Y_LSB, 8'h00};
            RD_YH:      o_cmd = {RD_Y_MSB, 8'h00};
            default:    o_cmd = '0;
        endcase
    end

    assign frame.is_write = (state == CFG_POWER) || (state == CFG_FORMAT);

    // the receive byte is complete by the closing count of a read frame
    assign o_capture_lo = frame.frame_done && ((state == RD_XL) || (state == RD_YL));
    assign o_commit_x   = frame.frame_done && (state == RD_XH);
    assign o_commit_y   = frame.frame_done && (state == RD_YH);

    a_state_legal : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        state inside {CFG_POWER, CFG_FORMAT, RD_XL, RD_XH, RD_YL, RD_YH}
    );

endmodule

// File: design/adxl_frame_if.sv
`timescale 1ns/1ps

interface adxl_frame_if;

    logic is_write;   // current frame ends at the write end count
    logic load;       // count 0, shifter takes the next command
    logic shift;      // even counts 12 to 42, next bit onto SDI
    logic sample;     // odd counts 27 to 41 of a read frame
    logic frame_done; // last count of the frame
    logic tx_en;      // counts 11 to 42, SDI carries the shift register

    modport timer (
        input  is_write,
        output load, shift, sample, frame_done, tx_en
    );

    modport seq (
        input  frame_done,
        output is_write
    );

    modport shifter (
        input  load, shift, sample, tx_en
    );

endinterface

// File: design/adxl_frame_timer.sv
`timescale 1ns/1ps

module adxl_frame_timer (
    input  logic         i_clk,
    input  logic         i_rst_n,
    adxl_frame_if.timer  frame,
    output logic         o_cs_n,
    output logic         o_spc
);
    import adxl_pkg::*;

    logic [FRAME_CNT_W-1:0] cnt;
    logic [FRAME_CNT_W-1:0] end_cnt;
    logic                   last;

    assign end_cnt = frame.is_write ? WRITE_FRAME_END : READ_FRAME_END;
    assign last    = (cnt == end_cnt);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (last) begin
            cnt <= '0; // next frame starts with the idle lead-in
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // both lines go back to idle on the closing count of a frame
    assign o_cs_n = (cnt <= CS_IDLE_LAST) || last;
    assign o_spc  = (cnt <= SPC_IDLE_LAST) || last || !cnt[0]; // falls on odd counts

    assign frame.load       = (cnt == '0);
    assign frame.frame_done = last;
    assign frame.tx_en      = (cnt >= BIT_FIRST) && (cnt <= READ_FRAME_END);

    // SDI moves on after each rising SPC, so it changes with the falling edge
    assign frame.shift = !cnt[0] && (cnt > BIT_FIRST) && (cnt <= READ_FRAME_END);

    // only read frames have anything worth capturing from the sensor
    assign frame.sample = cnt[0] && (cnt >= SAMPLE_FIRST) && (cnt <= SAMPLE_LAST)
                          && !frame.is_write;

    // the sensor sees SPC parked high whenever it is deselected
    a_spc_idle_high : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_cs_n |-> o_spc
    );

    // the end count must not change while a frame is running
    a_write_stable : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !frame.load |-> $stable(frame.is_write)
    );

endmodule

// File: design/adxl_pkg.sv
package adxl_pkg;

    // frame counter and the counts that shape every SPI frame
    localparam int FRAME_CNT_W = 7;

    localparam logic [FRAME_CNT_W-1:0] CS_IDLE_LAST    = 7'd9;  // chip select released up to here
    localparam logic [FRAME_CNT_W-1:0] SPC_IDLE_LAST   = 7'd10; // clock parked high up to here
    localparam logic [FRAME_CNT_W-1:0] BIT_FIRST       = 7'd11; // first count carrying a bit on SDI
    localparam logic [FRAME_CNT_W-1:0] SAMPLE_FIRST    = 7'd27; // first rising SPC of the data byte
    localparam logic [FRAME_CNT_W-1:0] SAMPLE_LAST     = 7'd41;
    localparam logic [FRAME_CNT_W-1:0] WRITE_FRAME_END = 7'd43;
    localparam logic [FRAME_CNT_W-1:0] READ_FRAME_END  = 7'd42;

    // write commands have bit 7 clear and no multibyte flag
    localparam logic [7:0] REG_POWER_CTL   = 8'h2D;
    localparam logic [7:0] REG_DATA_FORMAT = 8'h31;
    localparam logic [7:0] POWER_CTL_VAL   = 8'h08; // measure mode
    localparam logic [7:0] DATA_FORMAT_VAL = 8'h08; // full resolution, +/-2 g

    // read commands are the data register addresses with bit 7 set
    localparam logic [7:0] RD_X_LSB = 8'hB2;
    localparam logic [7:0] RD_X_MSB = 8'hB3;
    localparam logic [7:0] RD_Y_LSB = 8'hB4;
    localparam logic [7:0] RD_Y_MSB = 8'hB5;

    // address byte on top, data byte below, sent MSB first
    typedef logic [15:0] spi_cmd_t;

    typedef logic [15:0] accel_t;

    typedef enum logic [2:0] {
        CFG_POWER  = 3'd0,
        CFG_FORMAT = 3'd1,
        RD_XL      = 3'd2,
        RD_XH      = 3'd3,
        RD_YL      = 3'd4,
        RD_YH      = 3'd5
    } seq_state_t;

endpackage

// File: design/adxl_sample_store.sv
`timescale 1ns/1ps

module adxl_sample_store (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic [7:0]       i_rx_byte,
    input  logic             i_capture_lo,
    input  logic             i_commit_x,
    input  logic             i_commit_y,
    output adxl_pkg::accel_t o_accel_x,
    output adxl_pkg::accel_t o_accel_y,
    output logic             o_accel_valid
);

    logic [7:0] lo_byte; // low half waiting for its high byte

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            lo_byte <= '0;
        end else if (i_capture_lo) begin
            lo_byte <= i_rx_byte;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_accel_x     <= '0;
            o_accel_y     <= '0;
            o_accel_valid <= 1'b0;
        end else begin
            o_accel_valid <= i_commit_y; // Y closes the loop, so both axes are fresh
            if (i_commit_x) begin
                o_accel_x <= {i_rx_byte, lo_byte};
            end
            if (i_commit_y) begin
                o_accel_y <= {i_rx_byte, lo_byte};
            end
        end
    end

    // commit_y never comes on two clocks in a row, so valid stays a one-clock strobe
    a_valid_single : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_accel_valid |=> !o_accel_valid
    );

endmodule

// File: design/adxl_spi_shifter.sv
`timescale 1ns/1ps

module adxl_spi_shifter (
    input  logic               i_clk,
    input  logic               i_rst_n,
    adxl_frame_if.shifter      frame,
    input  adxl_pkg::spi_cmd_t i_cmd,
    input  logic               i_sdo,
    output logic               o_sdi,
    output logic [7:0]         o_rx_byte
);
    import adxl_pkg::*;

    spi_cmd_t   tx_reg;
    logic [7:0] rx_reg;

    // 16 shifts per frame leave the register empty before the next load
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_reg <= '0;
        end else if (frame.load) begin
            tx_reg <= i_cmd;
        end else if (frame.shift) begin
            tx_reg <= {tx_reg[14:0], 1'b0};
        end
    end

    // each bit stays on SDI for two clocks, one full SPC period
    assign o_sdi = frame.tx_en && tx_reg[15];

    // sensor sends MSB first, so bits enter at the bottom
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_reg <= '0;
        end else if (frame.sample) begin
            rx_reg <= {rx_reg[6:0], i_sdo};
        end
    end

    assign o_rx_byte = rx_reg;

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the ADXL345 reader testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_adxl345_xy_reader

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module "$TOP" --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -qx "=== PASS ===" "$LOG"
status=$?
if [ $status -eq 0 ]; then
    echo "simulation passed, log in $LOG"
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi

// File: src.f
design/adxl_pkg.sv
design/adxl_frame_if.sv
design/adxl_frame_timer.sv
design/adxl_cmd_sequencer.sv
design/adxl_spi_shifter.sv
design/adxl_sample_store.sv
design/adxl345_xy_reader.sv
bench/tb_adxl345_xy_reader.sv
